// ==== hdl/rs_branch_pkg.sv ====
`default_nettype none

package rs_branch_pkg;

   localparam int DATA_LEN    = 32;
   localparam int ADDR_LEN    = 32;
   localparam int RRF_SEL     = 6;
   localparam int SPECTAG_LEN = 5; // One-hot branch tag
   localparam int OPCODE_LEN  = 7;

   // Select widths below are sized for exactly four entries
   localparam int ENT_NUM = 4;
   localparam int ENT_SEL = 2;

   typedef logic [ENT_SEL-1:0] ent_addr_t;

   // While valid is low the low RRF_SEL bits of data hold the awaited tag
   typedef struct packed {
      logic [DATA_LEN-1:0] data;
      logic                valid;
   } operand_t;

   typedef struct packed {
      logic [DATA_LEN-1:0] data;
      logic [RRF_SEL-1:0]  dst;
      logic                kill; // Producer was squashed
   } result_bus_t;

   typedef struct packed {
      logic [ADDR_LEN-1:0]    pc;
      logic [DATA_LEN-1:0]    imm;
      logic [RRF_SEL-1:0]     rrftag;
      logic                   dstval;
      logic [SPECTAG_LEN-1:0] spectag;
      logic [OPCODE_LEN-1:0]  opcode;
   } payload_t;

   typedef struct packed {
      payload_t payload;
      operand_t src1;
      operand_t src2;
      logic     specbit;
   } alloc_req_t;

   typedef struct packed {
      payload_t            payload;
      logic [DATA_LEN-1:0] src1;
      logic [DATA_LEN-1:0] src2;
      logic                specbit;
   } issue_t;

endpackage

`default_nettype wire

// ==== hdl/operand_wakeup.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_wakeup #(
   parameter int NUM_RESULT_BUSES = 2
) (
   input  wire rs_branch_pkg::operand_t                           opr,
   input  wire rs_branch_pkg::result_bus_t [NUM_RESULT_BUSES-1:0] results,
   output rs_branch_pkg::operand_t                                resolved_opr
);

   logic [rs_branch_pkg::RRF_SEL-1:0] tag;
   logic [NUM_RESULT_BUSES-1:0]       live_match;

   assign tag = opr.data[rs_branch_pkg::RRF_SEL-1:0];

   always_comb begin
      resolved_opr = opr;
      if (!opr.valid) begin
         // Walk downwards so the lowest numbered bus wins
         for (int i = NUM_RESULT_BUSES - 1; i >= 0; i--) begin
            if (!results[i].kill && results[i].dst == tag) begin
               resolved_opr.data  = results[i].data;
               resolved_opr.valid = 1'b1;
            end
         end
      end
   end

   // Tag hits that come from live producers only
   always_comb begin
      for (int i = 0; i < NUM_RESULT_BUSES; i++) begin
         live_match[i] = (results[i].dst == tag) & ~results[i].kill;
      end
   end

   // Squashed results never wake a waiting operand
   always_comb begin
      assert final (opr.valid || (|live_match) || resolved_opr == opr)
         else $error("operand_wakeup: operand woken by killed result bus");
   end

endmodule

`default_nettype wire

// ==== hdl/rs_branch_entry.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_branch_entry #(
   parameter int NUM_RESULT_BUSES = 2
) (
   input  wire                                                    clk,
   input  wire                                                    reset,
   input  wire                                                    busy,
   input  wire                                                    we,
   input  wire rs_branch_pkg::alloc_req_t                         wdata,
   input  wire rs_branch_pkg::result_bus_t [NUM_RESULT_BUSES-1:0] results,
   output rs_branch_pkg::payload_t                                payload,
   output logic [rs_branch_pkg::DATA_LEN-1:0]                     ex_src1,
   output logic [rs_branch_pkg::DATA_LEN-1:0]                     ex_src2,
   output logic                                                   ready
);

   logic [rs_branch_pkg::DATA_LEN-1:0] src1_data;
   logic [rs_branch_pkg::DATA_LEN-1:0] src2_data;
   logic                               src1_valid;
   logic                               src2_valid;
   rs_branch_pkg::operand_t            src1;
   rs_branch_pkg::operand_t            src2;
   rs_branch_pkg::operand_t            next1;
   rs_branch_pkg::operand_t            next2;

   assign src1 = '{data: src1_data, valid: src1_valid};
   assign src2 = '{data: src2_data, valid: src2_valid};

   operand_wakeup #(
      .NUM_RESULT_BUSES(NUM_RESULT_BUSES)
   ) wakeup1_i (
      .opr         (src1),
      .results     (results),
      .resolved_opr(next1)
   );

   operand_wakeup #(
      .NUM_RESULT_BUSES(NUM_RESULT_BUSES)
   ) wakeup2_i (
      .opr         (src2),
      .results     (results),
      .resolved_opr(next2)
   );

   // Same-cycle bypass of a matching result
   assign ex_src1 = next1.data;
   assign ex_src2 = next2.data;

   assign ready = busy & src1_valid & src2_valid;

   always_ff @(posedge clk) begin
      if (reset) begin
         src1_valid <= 1'b0;
         src2_valid <= 1'b0;
      end else if (we) begin
         src1_valid <= wdata.src1.valid;
         src2_valid <= wdata.src2.valid;
      end else begin
         src1_valid <= next1.valid;
         src2_valid <= next2.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (we) begin
         payload   <= wdata.payload;
         src1_data <= wdata.src1.data;
         src2_data <= wdata.src2.data;
      end else begin
         src1_data <= next1.data; // Tag until woken
         src2_data <= next2.data;
      end
   end

   // The allocator only picks entries that busyvec shows as free
   assert property (@(posedge clk) disable iff (reset) we |-> !busy)
      else $error("rs_branch_entry: allocation onto a busy entry");

endmodule

`default_nettype wire

// ==== hdl/rs_branch_status.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_branch_status (
   input  wire                                                            clk,
   input  wire                                                            reset,
   input  wire                                                            we1,
   input  wire                                                            we2,
   input  wire rs_branch_pkg::ent_addr_t                                  waddr1,
   input  wire rs_branch_pkg::ent_addr_t                                  waddr2,
   input  wire                                                            wspecbit1,
   input  wire                                                            wspecbit2,
   input  wire                                                            clearbusy,
   input  wire rs_branch_pkg::ent_addr_t                                  issueaddr,
   input  wire                                                            prmiss,
   input  wire                                                            prsuccess,
   input  wire [rs_branch_pkg::SPECTAG_LEN-1:0]                           prtag,
   input  wire [rs_branch_pkg::SPECTAG_LEN-1:0]                           specfixtag,
   input  wire [rs_branch_pkg::ENT_NUM-1:0][rs_branch_pkg::SPECTAG_LEN-1:0] entry_spectag,
   output logic [rs_branch_pkg::ENT_NUM-1:0]                              busyvec,
   output logic                                                           specbit
);

   logic [rs_branch_pkg::ENT_NUM-1:0] specbitvec;
   logic [rs_branch_pkg::ENT_NUM-1:0] survive_vec; // Not on the mispredicted path
   logic [rs_branch_pkg::ENT_NUM-1:0] spec_keep;   // Not tagged with resolved branch
   logic [rs_branch_pkg::ENT_NUM-1:0] specbit_next;

   always_comb begin
      for (int i = 0; i < rs_branch_pkg::ENT_NUM; i++) begin
         survive_vec[i] = (entry_spectag[i] & specfixtag) == '0;
         spec_keep[i]   = entry_spectag[i] != prtag;
      end
   end

   assign specbit_next = specbitvec & spec_keep;

   // Issue sees the resolved bit in the cycle of the outcome
   assign specbit = prsuccess ? specbit_next[issueaddr] : specbitvec[issueaddr];

   always_ff @(posedge clk) begin
      if (reset) begin
         busyvec    <= '0;
         specbitvec <= '0;
      end else if (prmiss) begin
         busyvec    <= busyvec & survive_vec;
         specbitvec <= '0;
      end else if (prsuccess) begin
         specbitvec <= specbit_next;
         if (clearbusy) begin
            busyvec[issueaddr] <= 1'b0;
         end
      end else begin
         if (we1) begin
            busyvec[waddr1]    <= 1'b1;
            specbitvec[waddr1] <= wspecbit1;
         end
         if (we2) begin
            busyvec[waddr2]    <= 1'b1;
            specbitvec[waddr2] <= wspecbit2;
         end
         if (clearbusy) begin
            busyvec[issueaddr] <= 1'b0;
         end
      end
   end

   assert property (@(posedge clk) disable iff (reset)
                    (we1 && we2) |-> waddr1 != waddr2)
      else $error("rs_branch_status: dual allocation to one entry");

endmodule

`default_nettype wire

// ==== hdl/rs_branch.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_branch #(
   parameter int NUM_RESULT_BUSES = 2
) (
   input  wire                                                    clk,
   input  wire                                                    reset,
   input  wire                                                    we1,
   input  wire                                                    we2,
   input  wire rs_branch_pkg::ent_addr_t                          waddr1,
   input  wire rs_branch_pkg::ent_addr_t                          waddr2,
   input  wire rs_branch_pkg::alloc_req_t                         alloc1,
   input  wire rs_branch_pkg::alloc_req_t                         alloc2,
   input  wire                                                    clearbusy,
   input  wire rs_branch_pkg::ent_addr_t                          issueaddr,
   input  wire                                                    prmiss,
   input  wire                                                    prsuccess,
   input  wire [rs_branch_pkg::SPECTAG_LEN-1:0]                   prtag,
   input  wire [rs_branch_pkg::SPECTAG_LEN-1:0]                   specfixtag,
   input  wire rs_branch_pkg::result_bus_t [NUM_RESULT_BUSES-1:0] results,
   output logic [rs_branch_pkg::ENT_NUM-1:0]                      busyvec,
   output logic [rs_branch_pkg::ENT_NUM-1:0]                      ready,
   output rs_branch_pkg::issue_t                                  issue
);

   logic                                                             alloc_ok;
   logic                                                             we1_ok;
   logic                                                             we2_ok;
   logic                                                             issue_specbit;
   rs_branch_pkg::payload_t [rs_branch_pkg::ENT_NUM-1:0]             ent_payload;
   logic [rs_branch_pkg::ENT_NUM-1:0][rs_branch_pkg::DATA_LEN-1:0]    ent_src1;
   logic [rs_branch_pkg::ENT_NUM-1:0][rs_branch_pkg::DATA_LEN-1:0]    ent_src2;
   logic [rs_branch_pkg::ENT_NUM-1:0][rs_branch_pkg::SPECTAG_LEN-1:0] ent_spectag;

   // No allocation in a cycle carrying a prediction outcome
   assign alloc_ok = ~(prmiss | prsuccess);
   assign we1_ok   = we1 & alloc_ok;
   assign we2_ok   = we2 & alloc_ok;

   rs_branch_status status_i (
      .clk          (clk),
      .reset        (reset),
      .we1          (we1_ok),
      .we2          (we2_ok),
      .waddr1       (waddr1),
      .waddr2       (waddr2),
      .wspecbit1    (alloc1.specbit),
      .wspecbit2    (alloc2.specbit),
      .clearbusy    (clearbusy),
      .issueaddr    (issueaddr),
      .prmiss       (prmiss),
      .prsuccess    (prsuccess),
      .prtag        (prtag),
      .specfixtag   (specfixtag),
      .entry_spectag(ent_spectag),
      .busyvec      (busyvec),
      .specbit      (issue_specbit)
   );

   for (genvar i = 0; i < rs_branch_pkg::ENT_NUM; i++) begin : g_ent
      logic                      sel1;
      logic                      ent_we;
      rs_branch_pkg::alloc_req_t wdata;

      // Port 1 has priority for its target entry
      assign sel1   = we1_ok && waddr1 == rs_branch_pkg::ENT_SEL'(i);
      assign ent_we = sel1 || (we2_ok && waddr2 == rs_branch_pkg::ENT_SEL'(i));
      assign wdata  = sel1 ? alloc1 : alloc2;

      rs_branch_entry #(
         .NUM_RESULT_BUSES(NUM_RESULT_BUSES)
      ) entry_i (
         .clk    (clk),
         .reset  (reset),
         .busy   (busyvec[i]),
         .we     (ent_we),
         .wdata  (wdata),
         .results(results),
         .payload(ent_payload[i]),
         .ex_src1(ent_src1[i]),
         .ex_src2(ent_src2[i]),
         .ready  (ready[i])
      );

      assign ent_spectag[i] = ent_payload[i].spectag;
   end

   assign issue = '{
      payload: ent_payload[issueaddr],
      src1:    ent_src1[issueaddr],
      src2:    ent_src2[issueaddr],
      specbit: issue_specbit
   };

endmodule

`default_nettype wire

// ==== test/rs_branch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_branch_tb;

   localparam int NUM_BUSES      = 2;
   localparam int NUM_COLS       = 40;
   localparam int MAX_LINES      = 500;
   localparam int IDLE_TIMEOUT   = 20;
   localparam int TIMEOUT_CYCLES = 2000;

   logic                                       clk;
   logic                                       reset;
   logic                                       we1;
   logic                                       we2;
   rs_branch_pkg::ent_addr_t                   waddr1;
   rs_branch_pkg::ent_addr_t                   waddr2;
   rs_branch_pkg::alloc_req_t                  alloc1;
   rs_branch_pkg::alloc_req_t                  alloc2;
   logic                                       clearbusy;
   rs_branch_pkg::ent_addr_t                   issueaddr;
   logic                                       prmiss;
   logic                                       prsuccess;
   logic [rs_branch_pkg::SPECTAG_LEN-1:0]      prtag;
   logic [rs_branch_pkg::SPECTAG_LEN-1:0]      specfixtag;
   rs_branch_pkg::result_bus_t [NUM_BUSES-1:0] results;
   logic [rs_branch_pkg::ENT_NUM-1:0]          busyvec;
   logic [rs_branch_pkg::ENT_NUM-1:0]          ready;
   rs_branch_pkg::issue_t                      issue;

   logic [31:0] col [NUM_COLS]; // Current golden line
   int          errors;
   int          checks;
   int          vectors;
   int          file_line;
   int          first_draw;
   bit          aborted;

   rs_branch #(
      .NUM_RESULT_BUSES(NUM_BUSES)
   ) rs_branch_i (
      .clk       (clk),
      .reset     (reset),
      .we1       (we1),
      .we2       (we2),
      .waddr1    (waddr1),
      .waddr2    (waddr2),
      .alloc1    (alloc1),
      .alloc2    (alloc2),
      .clearbusy (clearbusy),
      .issueaddr (issueaddr),
      .prmiss    (prmiss),
      .prsuccess (prsuccess),
      .prtag     (prtag),
      .specfixtag(specfixtag),
      .results   (results),
      .busyvec   (busyvec),
      .ready     (ready),
      .issue     (issue)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic end_run();
      $display("Summary: %0d vectors, %0d checks, %0d errors", vectors, checks, errors);
      if (errors == 0 && !aborted) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   endtask

   task automatic abort_run(input string msg);
      aborted = 1'b1;
      errors++;
      $display("%s", msg);
      end_run();
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("MISMATCH at %0t: %s got %h expected %h (golden line %0d)",
                  $time, name, actual, expected, file_line);
      end
   endtask

   task automatic drive_preload(input bit en, input int a, input int b);
      we1    = en;
      we2    = en;
      waddr1 = a[1:0];
      waddr2 = b[1:0];
      alloc1 = '0;
      alloc2 = '0;
   endtask

   // Port fields start at column b, imm/opcode/dstval are never checked
   task automatic make_alloc(input int b, output rs_branch_pkg::alloc_req_t req);
      logic [31:0] fill;
      fill                = $urandom;
      req.payload.pc      = col[b+2];
      req.payload.imm     = $urandom;
      req.payload.rrftag  = col[b+3][5:0];
      req.payload.dstval  = fill[0];
      req.payload.spectag = col[b+4][4:0];
      req.payload.opcode  = fill[7:1];
      req.src1.data       = col[b+5];
      req.src1.valid      = col[b+6][0];
      req.src2.data       = col[b+7];
      req.src2.valid      = col[b+8][0];
      req.specbit         = col[b+9][0];
      if (col[b][0]) begin
         $display("Line %0d port %0d fill: imm %h opcode %h dstval %b", file_line,
                  b / 10 + 1, req.payload.imm, req.payload.opcode, req.payload.dstval);
      end
   endtask

   task automatic apply_line();
      make_alloc(0, alloc1);
      make_alloc(10, alloc2);
      we1        = col[0][0];
      waddr1     = col[1][1:0];
      we2        = col[10][0];
      waddr2     = col[11][1:0];
      clearbusy  = col[20][0];
      issueaddr  = col[21][1:0];
      prmiss     = col[22][0];
      prsuccess  = col[23][0];
      prtag      = col[24][4:0];
      specfixtag = col[25][4:0];
      for (int i = 0; i < NUM_BUSES; i++) begin
         results[i].kill = col[26+3*i][0];
         results[i].dst  = col[27+3*i][5:0];
         results[i].data = col[28+3*i];
      end
   endtask

   // Bypassed operands and resolved specbit show before the edge that stores them,
   // so an entry not written and not flushed already matches the line's result
   task automatic check_same_cycle();
      rs_branch_pkg::ent_addr_t a;
      a = col[21][1:0];
      if (col[32][0] && !col[22][0] &&
          !(col[0][0] && col[1][1:0] == a) && !(col[10][0] && col[11][1:0] == a)) begin
         check_value("issue.src1 before edge", issue.src1, col[35]);
         check_value("issue.src2 before edge", issue.src2, col[36]);
         check_value("issue.specbit before edge", issue.specbit, col[39]);
      end
   endtask

   task automatic check_line();
      check_value("busyvec", busyvec, col[33]);
      check_value("ready", ready, col[34]);
      if (col[32][0]) begin // Issue fields only where the line asks
         check_value("issue.src1", issue.src1, col[35]);
         check_value("issue.src2", issue.src2, col[36]);
         check_value("issue.pc", issue.payload.pc, col[37]);
         check_value("issue.rrftag", issue.payload.rrftag, col[38]);
         check_value("issue.specbit", issue.specbit, col[39]);
      end
   endtask

   // Hex tokens separated by blanks
   task automatic split_line(input string line, output int n);
      int    start;
      bit    in_tok;
      byte   c;
      string tok;
      n      = 0;
      start  = 0;
      in_tok = 1'b0;
      for (int i = 0; i <= line.len(); i++) begin
         c = (i < line.len()) ? line[i] : " ";
         if (c == " " || c == "\t" || c == "\n" || c == "\r") begin
            if (in_tok) begin
               tok = line.substr(start, i - 1);
               if (n < NUM_COLS) col[n] = tok.atohex();
               n++;
               in_tok = 1'b0;
            end
         end else if (!in_tok) begin
            in_tok = 1'b1;
            start  = i;
         end
      end
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      for (int i = 0; i < 10; i++) begin
         @(negedge clk);
         // Fill every entry so unallocated ones carry no X
         if (i == 1) drive_preload(1'b1, 0, 1);
         else if (i == 2) drive_preload(1'b1, 2, 3);
         else drive_preload(1'b0, 0, 1);
      end
      reset = 1'b0;
   endtask

   task automatic wait_idle(output bit ok);
      int n;
      ok = 1'b0;
      n  = 0;
      while (!ok && n < IDLE_TIMEOUT) begin
         @(posedge clk);
         #1;
         if (busyvec == '0 && ready == '0) ok = 1'b1;
         n++;
      end
   endtask

   task automatic run_vectors(input int fd);
      string line;
      int    n;
      int    code;
      file_line = 0;
      while (!$feof(fd) && file_line < MAX_LINES) begin
         code = $fgets(line, fd);
         file_line++;
         if (code != 0 && line.len() > 0 && line[0] != "#") begin
            split_line(line, n);
            if (n != 0 && n != NUM_COLS) begin
               errors++;
               $display("Golden line %0d has %0d columns instead of %0d",
                        file_line, n, NUM_COLS);
            end else if (n == NUM_COLS) begin
               @(negedge clk);
               apply_line();
               #1;
               check_same_cycle();
               @(posedge clk);
               #1.5; // Just before the next falling edge
               check_line();
               vectors++;
            end
         end
      end
      if (vectors == 0) begin
         errors++;
         $display("No test vectors were read from the golden file");
      end
   endtask

   initial begin : main
      int fd;
      bit ok;
      errors     = 0;
      checks     = 0;
      vectors    = 0;
      aborted    = 1'b0;
      first_draw = $urandom(45);
      $display("Random fill seed 45, first draw %h", first_draw);
      reset      = 1'b1;
      we1        = 1'b0;
      we2        = 1'b0;
      waddr1     = '0;
      waddr2     = '0;
      alloc1     = '0;
      alloc2     = '0;
      clearbusy  = 1'b0;
      issueaddr  = '0;
      prmiss     = 1'b0;
      prsuccess  = 1'b0;
      prtag      = '0;
      specfixtag = '0;
      for (int i = 0; i < NUM_BUSES; i++) begin
         results[i] = '{data: '0, dst: '0, kill: 1'b1}; // Idle bus
      end
      apply_reset();
      wait_idle(ok);
      if (!ok) begin
         abort_run("busyvec or ready did not clear after reset");
      end else begin
         fd = $fopen("test/rs_branch_golden.txt", "r");
         if (fd == 0) begin
            abort_run("Could not open the golden file test/rs_branch_golden.txt");
         end else begin
            run_vectors(fd);
            $fclose(fd);
            end_run();
         end
      end
   end

   initial begin : watchdog
      int n;
      n = 0;
      while (n < TIMEOUT_CYCLES) begin
         @(posedge clk);
         n++;
      end
      abort_run("Timeout, the run did not finish in time");
   end

endmodule

`default_nettype wire

// ==== test/rs_branch_golden.txt ====
# cols: port1 then port2 (we waddr pc rrftag spectag src1 v1 src2 v2 specbit), clr iaddr miss
#       succ prtag fixtag, bus0 bus1 (kill dst data), chk, busy ready src1 src2 pc rrftag specbit
# reset state
0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0  1 0 0 1 0 0  0 0 0 0 0 0 0 0
# dual allocation of entries 0 and 2
1 0 100 05 0 11 1 12 1 0  1 2 200 06 0 21 1 22 1 0  0 0 0 0 0 0  1 0 0 1 0 0  1 5 5 11 12 100 05 0
0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0  0 2 0 0 0 0  1 0 0 1 0 0  1 5 5 21 22 200 06 0
# entry 1 waits on tag 9, killed bus first, then live bus 1
1 1 300 07 0 9 0 32 1 0  0 0 0 0 0 0 0 0 0 0  0 1 0 0 0 0  1 0 0 1 0 0  1 7 5 9 32 300 07 0
0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0  0 1 0 0 0 0  1 0 0 1 9 dead  1 7 5 9 32 300 07 0
0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0  0 1 0 0 0 0  1 0 0 0 9 99  1 7 7 99 32 300 07 0
0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0  0 1 0 0 0 0  1 0 0 1 0 0  1 7 7 99 32 300 07 0
# issue entry 0, then reallocate it with entry 3
0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0  1 0 0 0 0 0  1 0 0 1 0 0  1 6 6 11 12 100 05 0
1 0 400 08 02 41 1 42 1 1  1 3 500 09 04 51 1 a 0 1  0 0 0 0 0 0  1 0 0 1 0 0  1 f 7 41 42 400 08 1
0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0  1 2 0 0 0 0  1 0 0 1 0 0  1 b 3 21 22 200 06 0
# prsuccess with prtag 04, allocation in the same cycle is dropped
1 2 600 0a 01 61 1 62 1 1  0 0 0 0 0 0 0 0 0 0  0 3 0 1 04 0  1 0 0 1 0 0  1 b 3 51 a 500 09 0
0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0  0 2 0 0 0 0  1 0 0 1 0 0  1 b 3 21 22 200 06 0
1 2 700 0b 08 71 1 72 1 1  0 0 0 0 0 0 0 0 0 0  0 3 0 0 0 0  1 0 0 0 a aa  1 f f 51 aa 500 09 0
0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0  0 2 0 0 0 0  1 0 0 1 0 0  1 f f 71 72 700 0b 1
# prmiss with fix tag 02 drops entry 0 and zeros all specbits
0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0  0 0 1 0 0 02  1 0 0 1 0 0  1 e e 41 42 400 08 0
0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0  0 2 0 0 0 0  1 0 0 1 0 0  1 e e 71 72 700 0b 0
0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0  1 1 0 0 0 0  1 0 0 1 0 0  1 c c 99 32 300 07 0
0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0  0 1 0 0 0 0  1 0 0 1 0 0  1 c c 99 32 300 07 0
# both buses carry tag c, bus 0 wins
1 0 800 0c 0 c 0 d 0 0  1 1 900 0d 0 91 1 92 1 0  0 0 0 0 0 0  1 0 0 1 0 0  1 f e c d 800 0c 0
0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0  0 c c0 0 c c1  1 f e c0 d 800 0c 0
0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0  1 d bad 0 d d1  1 f f c0 d1 800 0c 0
0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0  0 1 0 0 0 0  1 0 0 1 0 0  1 f f 91 92 900 0d 0

// ==== all.f ====
hdl/rs_branch_pkg.sv
hdl/operand_wakeup.sv
hdl/rs_branch_entry.sv
hdl/rs_branch_status.sv
hdl/rs_branch.sv
test/rs_branch_tb.sv
